//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dvbs2_mod
RTL_TOP   ?= dvbs2_mod_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+include
rtl/dvbs2_pkg.sv
rtl/dvbs2_cfg_regs.sv
rtl/ts_byte_intake.sv
rtl/bb_scrambler.sv
rtl/symbol_mapper.sv
rtl/dvbs2_mod_top.sv
tb/tb_dvbs2_mod.sv

//--- include/dvbs2_macros.svh
`ifndef DVBS2_MACROS_SVH
`define DVBS2_MACROS_SVH

// register port widths
`define DVB_DATA_W 32
`define DVB_ADDR_W 4

// register map
`define DVB_REG_MOD_MODE    4'd0 // 0 qpsk, 1 bpsk
`define DVB_REG_FREQ_INV    4'd1 // swap i and q
`define DVB_REG_SCRAMBLE_EN 4'd2
`define DVB_REG_SYM_AMP     4'd3
`define DVB_REG_BYTE_CNT    4'd4 // read only
`define DVB_REG_SYM_CNT     4'd5 // read only

`define DVB_AMP_DEFAULT  16'h2d41
`define DVB_PRBS_SEED    15'b100101010000000 // stage 1 in the msb
`define DVB_BAD_ADDR_TAG 16'hE000

`endif

//--- rtl/bb_scrambler.sv
`timescale 1ns/100ps
`include "dvbs2_macros.svh"

module bb_scrambler
	import dvbs2_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  ts_byte_t in_data,
	input  logic     in_syn,
	input  logic     scramble_en,
	input  logic     scr_ready,
	output logic     in_ready,
	output logic     scr_valid,
	output ts_byte_t scr_data
);

	prbs_state_t prbs;
	prbs_state_t prbs_next; // state after 8 steps
	ts_byte_t    prbs_mask; // next 8 output bits, first in msb
	logic        take;

	assign in_ready = !scr_valid || scr_ready;
	assign take     = in_valid && in_ready;

	// 1 + x^14 + x^15, feedback shifts into stage 1
	always_comb begin
		logic fb;
		prbs_next = prbs;
		for (int k = 7; k >= 0; k--) begin
			fb           = prbs_next[1] ^ prbs_next[0]; // stages 14 and 15
			prbs_mask[k] = fb;
			prbs_next    = {fb, prbs_next[14:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			scr_valid <= 1'b0;
			prbs      <= `DVB_PRBS_SEED;
		end else begin
			if (take) begin
				scr_valid <= 1'b1;
				if (in_syn) prbs <= `DVB_PRBS_SEED; // reload on sync byte
				else if (scramble_en) prbs <= prbs_next;
			end else if (scr_ready) begin
				scr_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			if (!in_syn && scramble_en) scr_data <= in_data ^ prbs_mask;
			else scr_data <= in_data; // sync or bypass
		end
	end

endmodule

//--- rtl/dvbs2_cfg_regs.sv
`timescale 1ns/100ps
`include "dvbs2_macros.svh"

module dvbs2_cfg_regs
	import dvbs2_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wen,
	input  reg_addr_t  waddr,
	input  cfg_word_t  wdata,
	input  byte_strb_t wstrb,
	input  logic       ren,
	input  reg_addr_t  raddr,
	input  logic       byte_accept,
	input  logic       sym_valid,
	output cfg_word_t  rdata,
	output logic       mod_mode,
	output logic       freq_inv,
	output logic       scramble_en,
	output sample_t    sym_amp
);

	logic       cmd_pend; // write command taken from the port
	reg_addr_t  cmd_addr;
	cfg_word_t  cmd_data;
	byte_strb_t cmd_strb;
	logic       wr_pend;  // staged write waiting for commit
	reg_addr_t  wr_addr;
	cfg_word_t  wr_data;
	byte_strb_t wr_strb;
	cfg_word_t  byte_cnt;
	cfg_word_t  sym_cnt;

	// register the write command
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_pend <= 1'b0;
			wr_pend  <= 1'b0;
		end else begin
			cmd_pend <= wen;
			wr_pend  <= cmd_pend;
		end
	end

	always_ff @(posedge clk) begin
		if (wen) begin
			cmd_addr <= waddr;
			cmd_data <= wdata;
			cmd_strb <= wstrb;
		end
	end

	// merge the command into the staging word
	always_ff @(posedge clk) begin
		if (cmd_pend) begin
			wr_addr <= cmd_addr;
			wr_strb <= cmd_strb;
			for (int b = 0; b < `DVB_DATA_W/8; b++) begin
				if (cmd_strb[b]) begin
					wr_data[8*b +: 8] <= cmd_data[8*b +: 8]; // strobed bytes only
				end
			end
		end
	end

	// commit staged word into the strobed bytes of the field
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mod_mode    <= 1'b0;
			freq_inv    <= 1'b0;
			scramble_en <= 1'b1;
			sym_amp     <= `DVB_AMP_DEFAULT;
		end else if (wr_pend) begin
			case (wr_addr)
				`DVB_REG_MOD_MODE: if (wr_strb[0]) mod_mode <= wr_data[0];
				`DVB_REG_FREQ_INV: if (wr_strb[0]) freq_inv <= wr_data[0];
				`DVB_REG_SCRAMBLE_EN: if (wr_strb[0]) scramble_en <= wr_data[0];
				`DVB_REG_SYM_AMP: begin
					if (wr_strb[0]) sym_amp[7:0] <= wr_data[7:0];
					if (wr_strb[1]) sym_amp[15:8] <= wr_data[15:8];
				end
				default: begin
				end // counters and holes ignore writes
			endcase
		end
	end

	// activity counters
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			sym_cnt  <= '0;
		end else begin
			if (byte_accept) byte_cnt <= byte_cnt + 1'b1;
			if (sym_valid) sym_cnt <= sym_cnt + 1'b1;
		end
	end

	// readback that holds between reads
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			case (raddr)
				`DVB_REG_MOD_MODE:    rdata <= {{(`DVB_DATA_W-1){1'b0}}, mod_mode};
				`DVB_REG_FREQ_INV:    rdata <= {{(`DVB_DATA_W-1){1'b0}}, freq_inv};
				`DVB_REG_SCRAMBLE_EN: rdata <= {{(`DVB_DATA_W-1){1'b0}}, scramble_en};
				`DVB_REG_SYM_AMP:     rdata <= {{(`DVB_DATA_W-16){1'b0}}, sym_amp};
				`DVB_REG_BYTE_CNT:    rdata <= byte_cnt;
				`DVB_REG_SYM_CNT:     rdata <= sym_cnt;
				default: begin
					rdata <= {`DVB_BAD_ADDR_TAG, {(`DVB_DATA_W/2-`DVB_ADDR_W){1'b0}}, raddr};
				end
			endcase
		end
	end

endmodule

//--- rtl/dvbs2_mod_top.sv
`timescale 1ns/100ps

module dvbs2_mod_top
	import dvbs2_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wen,
	input  reg_addr_t  waddr,
	input  cfg_word_t  wdata,
	input  byte_strb_t wstrb,
	input  logic       ren,
	input  reg_addr_t  raddr,
	output cfg_word_t  rdata,
	input  logic       ts_req,
	input  ts_byte_t   ts_data,
	input  logic       ts_syn,
	output logic       ts_ack,
	output logic       sym_valid,
	output sample_t    sym_i,
	output sample_t    sym_q
);

	logic     mod_mode;
	logic     freq_inv;
	logic     scramble_en;
	sample_t  sym_amp;
	logic     byte_accept;
	logic     in_valid;
	logic     in_ready;
	ts_byte_t in_data;
	logic     in_syn;
	logic     scr_valid;
	logic     scr_ready;
	ts_byte_t scr_data;

	dvbs2_cfg_regs u_cfg_regs (
		.clk(clk), .rst_n(rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.byte_accept(byte_accept), .sym_valid(sym_valid),
		.mod_mode(mod_mode), .freq_inv(freq_inv),
		.scramble_en(scramble_en), .sym_amp(sym_amp)
	);

	ts_byte_intake u_intake (
		.clk(clk), .rst_n(rst_n),
		.ts_req(ts_req), .ts_data(ts_data), .ts_syn(ts_syn), .ts_ack(ts_ack),
		.in_valid(in_valid), .in_data(in_data), .in_syn(in_syn), .in_ready(in_ready),
		.byte_accept(byte_accept)
	);

	bb_scrambler u_scrambler (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_data(in_data), .in_syn(in_syn), .in_ready(in_ready),
		.scramble_en(scramble_en),
		.scr_valid(scr_valid), .scr_data(scr_data), .scr_ready(scr_ready)
	);

	symbol_mapper u_mapper (
		.clk(clk), .rst_n(rst_n),
		.scr_valid(scr_valid), .scr_data(scr_data), .scr_ready(scr_ready),
		.mod_mode(mod_mode), .freq_inv(freq_inv), .sym_amp(sym_amp),
		.sym_valid(sym_valid), .sym_i(sym_i), .sym_q(sym_q)
	);

endmodule

//--- rtl/dvbs2_pkg.sv
`include "dvbs2_macros.svh"

package dvbs2_pkg;

	// register port
	typedef logic [`DVB_DATA_W-1:0] cfg_word_t;
	typedef logic [`DVB_ADDR_W-1:0] reg_addr_t;
	typedef logic [`DVB_DATA_W/8-1:0] byte_strb_t;

	// transport stream byte
	typedef logic [7:0] ts_byte_t;

	// i or q sample, also the amplitude setting
	typedef logic signed [15:0] sample_t;

	// energy dispersal register, stage 1 in bit 14
	typedef logic [14:0] prbs_state_t;

	// four-phase intake FSM
	typedef enum logic [1:0] {
		IDLE,    // waiting for req
		HOLD,    // ack high until req drops
		RELEASE  // ack falls here
	} intake_state_t;

endpackage

//--- rtl/symbol_mapper.sv
`timescale 1ns/100ps

module symbol_mapper
	import dvbs2_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     scr_valid,
	input  ts_byte_t scr_data,
	input  logic     mod_mode,
	input  logic     freq_inv,
	input  sample_t  sym_amp,
	output logic     scr_ready,
	output logic     sym_valid,
	output sample_t  sym_i,
	output sample_t  sym_q
);

	logic       busy;
	logic [2:0] sym_left;  // symbols after the current one
	ts_byte_t   shift;     // current symbol bits in the msbs
	logic       bpsk;      // settings latched per byte
	logic       inv;
	sample_t    amp;
	logic       last;
	logic       take;
	sample_t    re;
	sample_t    im;

	assign last      = busy && (sym_left == 3'd0);
	assign scr_ready = !busy || last; // next byte taken on the last symbol
	assign take      = scr_valid && scr_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			sym_left <= 3'd0;
		end else if (take) begin
			busy     <= 1'b1;
			sym_left <= mod_mode ? 3'd7 : 3'd3;
		end else if (busy) begin
			if (last) busy <= 1'b0;
			else sym_left <= sym_left - 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			shift <= scr_data;
			bpsk  <= mod_mode;
			inv   <= freq_inv;
			amp   <= sym_amp;
		end else if (busy) begin
			shift <= bpsk ? {shift[6:0], 1'b0} : {shift[5:0], 2'b00};
		end
	end

	// 0 maps to +amp, 1 to -amp
	always_comb begin
		re = shift[7] ? -amp : amp;
		if (bpsk) im = '0;
		else im = shift[6] ? -amp : amp;
	end

	assign sym_valid = busy;
	assign sym_i     = inv ? im : re; // spectrum inversion swaps i and q
	assign sym_q     = inv ? re : im;

endmodule

//--- rtl/ts_byte_intake.sv
`timescale 1ns/100ps

module ts_byte_intake
	import dvbs2_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ts_req,
	input  ts_byte_t ts_data,
	input  logic     ts_syn,
	input  logic     in_ready,
	output logic     ts_ack,
	output logic     in_valid,
	output ts_byte_t in_data,
	output logic     in_syn,
	output logic     byte_accept
);

	intake_state_t state;
	logic          take;

	// buffer counts as empty when its byte leaves this cycle
	assign take = (state == IDLE) && ts_req && (!in_valid || in_ready);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= IDLE;
			ts_ack      <= 1'b0;
			in_valid    <= 1'b0;
			byte_accept <= 1'b0;
		end else begin
			byte_accept <= take; // one pulse per handshake
			case (state)
				IDLE: begin
					if (take) begin
						ts_ack <= 1'b1;
						state  <= HOLD;
					end
				end
				HOLD: if (!ts_req) state <= RELEASE; // source let go
				RELEASE: begin
					ts_ack <= 1'b0;
					state  <= IDLE;
				end
				default: state <= IDLE;
			endcase
			if (take) in_valid <= 1'b1;
			else if (in_ready) in_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			in_data <= ts_data;
			in_syn  <= ts_syn;
		end
	end

endmodule

//--- tb/tb_dvbs2_mod.sv
`timescale 1ns/100ps
`include "dvbs2_macros.svh"

module tb_dvbs2_mod
	import dvbs2_pkg::*;
();

	localparam int TIMEOUT     = 200;  // cycles per handshake wait
	localparam int DRAIN_LIMIT = 4000; // cycles for the pipeline to empty

	logic       clk = 1'b0;
	logic       rst_n;
	logic       wen;
	reg_addr_t  waddr;
	cfg_word_t  wdata;
	byte_strb_t wstrb;
	logic       ren;
	reg_addr_t  raddr;
	cfg_word_t  rdata;
	logic       ts_req;
	ts_byte_t   ts_data;
	logic       ts_syn;
	logic       ts_ack;
	logic       sym_valid;
	sample_t    sym_i;
	sample_t    sym_q;

	logic        sh_mode; // shadow registers
	logic        sh_inv;
	logic        sh_scr;
	sample_t     sh_amp;
	logic [1:15] lfsr;    // reference prbs indexed by stage number
	sample_t     exp_i[$];
	sample_t     exp_q[$];
	int          errors = 0;
	int          checks = 0;
	int          bytes_sent = 0;
	int          sym_seen = 0;
	int          e0;
	int          b0;
	int          s0;
	reg_addr_t   addr;

	dvbs2_mod_top u_dut (
		.clk(clk), .rst_n(rst_n),
		.wen(wen), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
		.ren(ren), .raddr(raddr), .rdata(rdata),
		.ts_req(ts_req), .ts_data(ts_data), .ts_syn(ts_syn), .ts_ack(ts_ack),
		.sym_valid(sym_valid), .sym_i(sym_i), .sym_q(sym_q)
	);

	always #10 clk = ~clk;

	function automatic cfg_word_t expected_reg(input reg_addr_t a);
		case (a)
			`DVB_REG_MOD_MODE:    return {31'd0, sh_mode};
			`DVB_REG_FREQ_INV:    return {31'd0, sh_inv};
			`DVB_REG_SCRAMBLE_EN: return {31'd0, sh_scr};
			`DVB_REG_SYM_AMP:     return {16'd0, sh_amp};
			`DVB_REG_BYTE_CNT:    return cfg_word_t'(bytes_sent);
			`DVB_REG_SYM_CNT:     return cfg_word_t'(sym_seen);
			default:              return {`DVB_BAD_ADDR_TAG, 12'd0, a};
		endcase
	endfunction

	task automatic write_reg(input reg_addr_t a, input cfg_word_t data, input byte_strb_t strb);
		@(negedge clk);
		wen   = 1'b1;
		waddr = a;
		wdata = data;
		wstrb = strb;
		@(negedge clk);
		wen = 1'b0;
		repeat (2) @(negedge clk); // commit lands two edges after wen is sampled
		case (a)
			`DVB_REG_MOD_MODE:    if (strb[0]) sh_mode = data[0];
			`DVB_REG_FREQ_INV:    if (strb[0]) sh_inv = data[0];
			`DVB_REG_SCRAMBLE_EN: if (strb[0]) sh_scr = data[0];
			`DVB_REG_SYM_AMP: begin
				if (strb[0]) sh_amp[7:0] = data[7:0];
				if (strb[1]) sh_amp[15:8] = data[15:8];
			end
			default: ; // read-only and holes
		endcase
	endtask

	task automatic check_reg(input reg_addr_t a, input cfg_word_t exp);
		@(negedge clk);
		ren   = 1'b1;
		raddr = a;
		@(negedge clk);
		ren = 1'b0;
		checks++;
		if (rdata !== exp) begin
			errors++;
			$display("[ERROR] rdata at address %0d: got %h, expected %h", a, rdata, exp);
		end
	endtask

	// expected symbols of one scrambled byte in msb-first order
	task automatic push_symbols(input ts_byte_t b);
		sample_t pos;
		sample_t neg;
		sample_t re;
		sample_t im;
		int      n;
		pos = sh_amp;
		neg = -sh_amp;
		n   = sh_mode ? 8 : 4;
		for (int s = 0; s < n; s++) begin
			if (sh_mode) begin
				re = b[7-s] ? neg : pos;
				im = '0;
			end else begin
				re = b[7-2*s] ? neg : pos;
				im = b[6-2*s] ? neg : pos;
			end
			exp_i.push_back(sh_inv ? im : re); // inversion swaps the rails
			exp_q.push_back(sh_inv ? re : im);
		end
	endtask

	task automatic model_byte(input ts_byte_t data, input logic syn);
		ts_byte_t b;
		logic     prbs_bit;
		b = data;
		if (syn) begin
			lfsr = `DVB_PRBS_SEED; // sync byte passes clear
		end else if (sh_scr) begin
			for (int k = 7; k >= 0; k--) begin
				prbs_bit = lfsr[14] ^ lfsr[15];
				b[k]     = b[k] ^ prbs_bit;
				lfsr     = {prbs_bit, lfsr[1:14]};
			end
		end
		push_symbols(b);
	endtask

	// four-phase source that ends on a falling edge
	task automatic send_byte(input ts_byte_t data, input logic syn, input int max_gap);
		int gap;
		int t;
		gap = (max_gap > 0) ? int'($urandom_range(max_gap)) : 0;
		repeat (gap) @(negedge clk);
		ts_data = data;
		ts_syn  = syn;
		ts_req  = 1'b1;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!ts_ack && t < TIMEOUT);
		if (!ts_ack) begin
			errors++;
			$display("timeout: ts_ack never rose for byte %h", data);
		end else begin
			model_byte(data, syn);
			bytes_sent++;
		end
		ts_req = 1'b0;
		t = 0;
		while (ts_ack && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (ts_ack) begin
			errors++;
			$display("timeout: ts_ack stayed high after ts_req dropped");
		end
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while ((exp_i.size() != 0 || sym_valid) && t < DRAIN_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (exp_i.size() != 0 || sym_valid) begin
			errors++;
			$display("timeout: pipeline did not drain, %0d symbols never came", exp_i.size());
		end
		repeat (2) @(negedge clk);
	endtask

	task automatic check_stream(input int per_byte);
		int want;
		want = per_byte * (bytes_sent - b0);
		checks++;
		if (sym_seen - s0 != want) begin
			errors++;
			$display("[ERROR] sym_valid count: got %h, expected %h", sym_seen - s0, want);
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %s (%0d errors)", num, name,
			(errors == e0) ? "pass" : "fail", errors - e0);
	endtask

	// symbol monitor
	always @(negedge clk) begin
		if (rst_n && sym_valid) begin
			sym_seen++;
			if (exp_i.size() == 0) begin
				errors++;
				$display("sym_valid was high while no symbol was expected");
			end else begin
				checks++;
				if (sym_i !== exp_i[0]) begin
					errors++;
					$display("[ERROR] sym_i: got %h, expected %h", sym_i, exp_i[0]);
				end
				if (sym_q !== exp_q[0]) begin
					errors++;
					$display("[ERROR] sym_q: got %h, expected %h", sym_q, exp_q[0]);
				end
				void'(exp_i.pop_front());
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		void'($urandom(32'h73a51bc1));
		rst_n   = 1'b0;
		wen     = 1'b0;
		waddr   = '0;
		wdata   = '0;
		wstrb   = '0;
		ren     = 1'b0;
		raddr   = '0;
		ts_req  = 1'b0;
		ts_data = '0;
		ts_syn  = 1'b0;
		sh_mode = 1'b0;
		sh_inv  = 1'b0;
		sh_scr  = 1'b1;
		sh_amp  = `DVB_AMP_DEFAULT;
		lfsr    = `DVB_PRBS_SEED;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		e0 = errors;
		checks++;
		if (rdata !== '0) begin
			errors++;
			$display("[ERROR] rdata after reset: got %h, expected %h", rdata, 32'h0);
		end
		for (int a = 0; a < 16; a++) check_reg(reg_addr_t'(a), expected_reg(reg_addr_t'(a)));
		report_test(1, "reset and readback");

		e0 = errors;
		repeat (40) begin
			addr = reg_addr_t'($urandom_range(5));
			write_reg(addr, cfg_word_t'($urandom), byte_strb_t'($urandom));
			check_reg(addr, expected_reg(addr));
		end
		report_test(2, "strobed writes");

		write_reg(`DVB_REG_MOD_MODE, 32'd0, 4'hf); // back to defaults for qpsk
		write_reg(`DVB_REG_FREQ_INV, 32'd0, 4'hf);
		write_reg(`DVB_REG_SCRAMBLE_EN, 32'd1, 4'hf);
		write_reg(`DVB_REG_SYM_AMP, {16'd0, `DVB_AMP_DEFAULT}, 4'hf);
		e0 = errors;
		b0 = bytes_sent;
		s0 = sym_seen;
		for (int i = 0; i < 48; i++) send_byte(ts_byte_t'($urandom), (i % 8) == 0, 3);
		wait_idle();
		check_stream(4);
		report_test(3, "qpsk stream");

		write_reg(`DVB_REG_MOD_MODE, 32'd1, 4'h1);
		write_reg(`DVB_REG_FREQ_INV, 32'd1, 4'h1);
		write_reg(`DVB_REG_SYM_AMP, cfg_word_t'($urandom), 4'h3);
		e0 = errors;
		b0 = bytes_sent;
		s0 = sym_seen;
		for (int i = 0; i < 24; i++) send_byte(ts_byte_t'($urandom), (i % 8) == 0, 3);
		wait_idle();
		check_stream(8);
		report_test(4, "bpsk with inversion");

		write_reg(`DVB_REG_SCRAMBLE_EN, 32'd0, 4'h1);
		write_reg(`DVB_REG_FREQ_INV, 32'd0, 4'h1);
		e0 = errors;
		b0 = bytes_sent;
		s0 = sym_seen;
		for (int i = 0; i < 32; i++) send_byte(ts_byte_t'($urandom), (i % 8) == 0, 0);
		wait_idle();
		check_stream(8);
		report_test(5, "bypass and back-pressure");

		e0 = errors;
		check_reg(`DVB_REG_BYTE_CNT, expected_reg(`DVB_REG_BYTE_CNT));
		check_reg(`DVB_REG_SYM_CNT, expected_reg(`DVB_REG_SYM_CNT));
		report_test(6, "activity counters");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
